// File: fg_checker.sv
`timescale 1ns/1ns

module fg_checker #(
	parameter int address_depth = 8
) (
	input  logic                            clock,
	input  logic                            reset,
	input  logic                            start,
	input  fgen_pkg::pattern_mode_t         mode,
	input  logic                            loaded,
	input  logic [fgen_pkg::word_width-1:0] word_out,
	input  logic                            word_strobe,
	input  logic                            bit_out,
	output int                              error_count,
	output int                              words_checked,
	output int                              rise_count
);
	import fgen_pkg::*;

	localparam int ram_words = 2 ** address_depth;

	// expected ram content for the mode latched by the last accepted start
	logic [word_width-1:0] model_ram [0:ram_words-1];
	logic                  writing;
	logic                  loaded_model;
	logic                  started;
	logic                  prev_loaded;
	logic                  seen_strobe;
	logic [word_width-1:0] frame;
	int                    edge_count;
	int                    play_index;
	int                    gap;
	int                    bits_left;

	// x^31 + x^28 + 1, shift left
	function automatic logic [prbs_width-1:0] lfsr_next(input logic [prbs_width-1:0] s);
		return {s[prbs_width-2:0], s[30] ^ s[27]};
	endfunction

	// deterministic word at address a
	function automatic logic [word_width-1:0] pattern_at(input pattern_mode_t m, input int a);
		int                    top;
		int                    low;
		int                    k;
		logic [word_width-1:0] w;
		top = (a >> (address_depth - 8)) & 'hff;
		low = a & ((1 << (address_depth - 8)) - 1);
		k   = (a >> (address_depth - 3)) & 7;
		w   = '0;
		case (m)
			mode_ramp: w = a[word_width-1:0];
			mode_marker: begin
				case (a % 32)
					0:       w = 8'hff;
					1:       w = top[word_width-1:0];
					2:       w = low[word_width-1:0];
					3:       w = 8'hff;
					default: w = '0;
				endcase
			end
			mode_boundary: begin
				if (a % 64 == 0) w = top[word_width-1:0];
			end
			mode_pulse_width: begin
				// k+1 ones from the msb down
				if (a % 128 == 0) begin
					for (int i = 0; i <= k; i++) w[word_width-1-i] = 1'b1;
				end
			end
			default: w = '0;
		endcase
		return w;
	endfunction

	task automatic fill_model(input pattern_mode_t m);
		logic [prbs_width-1:0] state;
		state = prbs_seed;
		for (int a = 0; a < ram_words; a++) begin
			// random word at a is the state after a steps
			if (m == mode_random) model_ram[a] = state[word_width-1:0];
			else model_ram[a] = pattern_at(m, a);
			state = lfsr_next(state);
		end
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("ERR t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
		error_count++;
	endtask

	task automatic report_failure(input string what);
		$display("error at t=%0t: %s", $time, what);
		error_count++;
	endtask

	always @(posedge clock) begin
		if (reset) begin
			writing       = 1'b0;
			loaded_model  = 1'b0;
			started       = 1'b0;
			prev_loaded   = 1'b0;
			seen_strobe   = 1'b0;
			frame         = '0;
			edge_count    = 0;
			play_index    = 0;
			gap           = 0;
			bits_left     = 0;
			error_count   = 0;
			words_checked = 0;
			rise_count    = 0;
		end else begin
			// outputs seen here were set by the previous edge
			if (!started && (loaded || word_strobe || bit_out))
				report_failure("outputs active before the first start");
			if (loaded !== loaded_model) report_mismatch("loaded", loaded_model, loaded);
			if (loaded && !prev_loaded) rise_count++;
			prev_loaded = loaded;
			// serial frame, msb first
			if (bits_left > 0) begin
				if (bit_out !== frame[word_width-1])
					report_mismatch("bit_out", frame[word_width-1], bit_out);
				frame     = frame << 1;
				bits_left = bits_left - 1;
			end
			gap++;
			if (word_strobe) begin
				if (!loaded) report_failure("word_strobe high while loaded is low");
				if (seen_strobe && gap != word_width)
					report_failure($sformatf("strobes %0d cycles apart", gap));
				if (word_out !== model_ram[play_index])
					report_mismatch("word_out", model_ram[play_index], word_out);
				words_checked++;
				play_index  = (play_index + 1) % ram_words;
				seen_strobe = 1'b1;
				gap         = 0;
				frame       = word_out;
				bits_left   = word_width;
			end
			// playback restarts from address 0
			if (!loaded) begin
				play_index  = 0;
				seen_strobe = 1'b0;
			end
			// loader latching, start ignored while writing
			if (!writing && start) begin
				writing       = 1'b1;
				started       = 1'b1;
				edge_count    = 0;
				loaded_model  = 1'b0;
				words_checked = 0;
				fill_model(mode);
			end else if (writing) begin
				edge_count++;
				if (edge_count == ram_words + 1) begin
					writing      = 1'b0;
					loaded_model = 1'b1;
				end
			end
		end
	end

endmodule

// File: fgen_pkg.sv
package fgen_pkg;

	// one waveform word, also one serial frame on bit_out
	// every pattern is defined on 8 bits
	localparam int word_width = 8;

	// fibonacci lfsr length
	localparam int prbs_width = 31;

	// lfsr state right after a reseed
	localparam logic [prbs_width-1:0] prbs_seed = 31'h5a5a5a5;

	// waveform patterns the loader can write
	typedef enum logic [2:0] {
		mode_ramp        = 3'd0,
		mode_marker      = 3'd1,
		mode_boundary    = 3'd2,
		mode_pulse_width = 3'd3,
		mode_random      = 3'd4
	} pattern_mode_t;

	// ram loader fsm
	typedef enum logic [1:0] {
		load_idle    = 2'd0,
		load_writing = 2'd1,
		load_done    = 2'd2
	} loader_state_t;

endpackage

// File: flist.f
fgen_pkg.sv
prbs_generator.sv
pattern_synthesizer.sv
ram_loader.sv
waveform_playback.sv
word_serializer.sv
function_generator.sv
fg_checker.sv
function_generator_tb.sv

// File: function_generator.sv
`timescale 1ns/1ns

module function_generator #(
	parameter int address_depth = 14
) (
	input  logic                            clock,
	input  logic                            reset,
	input  logic                            start,
	input  fgen_pkg::pattern_mode_t         mode,
	output logic                            loaded,
	output logic [fgen_pkg::word_width-1:0] word_out,
	output logic                            word_strobe,
	output logic                            bit_out
);
	import fgen_pkg::*;

	// marker patterns need a full top byte of address
	if (address_depth < 8) begin : g_depth_check
		$error("address_depth must be at least 8");
	end

	pattern_mode_t            latched_mode;
	logic [address_depth-1:0] load_address;
	logic [word_width-1:0]    pattern_word;
	logic [word_width-1:0]    prbs_word;
	logic                     write_enable;
	logic [address_depth-1:0] write_address;
	logic [word_width-1:0]    write_data;
	logic                     prbs_reseed;

	// a start inside a write burst is ignored by the loader
	// keep it from restarting the prbs as well
	assign prbs_reseed = start & ~write_enable;

	prbs_generator u_prbs (
		.clock     (clock),
		.reset     (reset),
		.reseed    (prbs_reseed),
		.advance   (write_enable),
		.prbs_word (prbs_word)
	);

	pattern_synthesizer #(
		.address_depth (address_depth)
	) u_pattern (
		.load_address (load_address),
		.mode         (latched_mode),
		.pattern_word (pattern_word)
	);

	ram_loader #(
		.address_depth (address_depth)
	) u_loader (
		.clock         (clock),
		.reset         (reset),
		.start         (start),
		.mode          (mode),
		.pattern_word  (pattern_word),
		.prbs_word     (prbs_word),
		.latched_mode  (latched_mode),
		.load_address  (load_address),
		.write_enable  (write_enable),
		.write_address (write_address),
		.write_data    (write_data),
		.loaded        (loaded)
	);

	waveform_playback #(
		.address_depth (address_depth)
	) u_playback (
		.clock         (clock),
		.reset         (reset),
		.write_enable  (write_enable),
		.write_address (write_address),
		.write_data    (write_data),
		.loaded        (loaded),
		.word_out      (word_out),
		.word_strobe   (word_strobe)
	);

	// serial stream at the word clock, one bit per clock
	word_serializer u_serializer (
		.clock       (clock),
		.reset       (reset),
		.word_out    (word_out),
		.word_strobe (word_strobe),
		.bit_out     (bit_out)
	);

endmodule

// File: function_generator_tb.sv
`timescale 1ns/1ns

module function_generator_tb;
	import fgen_pkg::*;

	localparam int address_depth = 8;
	localparam int num_tests     = 7;
	// loaded needs 2^D+1 edges, some margin on top
	localparam int load_timeout  = 2 ** address_depth + 20;
	// cycles allowed per played word
	localparam int word_timeout  = word_width + 4;

	typedef enum int {
		act_load,
		act_restart,
		act_reload
	} action_t;

	logic                  clock = 1'b0;
	logic                  reset;
	logic                  start;
	pattern_mode_t         mode;
	logic                  loaded;
	logic [word_width-1:0] word_out;
	logic                  word_strobe;
	logic                  bit_out;
	int                    error_count;
	int                    words_checked;
	int                    rise_count;

	// test table, one column per array
	string         test_name [num_tests] = '{"ramp", "marker", "boundary", "pulse_width",
		"random_twice", "start_while_loading", "reload_marker"};
	// the ignored start lands in a random load, so a stray prbs reseed shows up too
	pattern_mode_t test_mode [num_tests] = '{mode_ramp, mode_marker, mode_boundary,
		mode_pulse_width, mode_random, mode_random, mode_marker};
	// more than 256 words wraps past the last address
	int            test_words [num_tests] = '{300, 260, 260, 260, 260, 40, 40};
	action_t       test_action [num_tests] = '{act_load, act_load, act_load, act_load,
		act_reload, act_restart, act_load};

	always #10 clock = ~clock;

	function_generator #(
		.address_depth (address_depth)
	) dut (
		.clock       (clock),
		.reset       (reset),
		.start       (start),
		.mode        (mode),
		.loaded      (loaded),
		.word_out    (word_out),
		.word_strobe (word_strobe),
		.bit_out     (bit_out)
	);

	fg_checker #(
		.address_depth (address_depth)
	) u_checker (
		.clock         (clock),
		.reset         (reset),
		.start         (start),
		.mode          (mode),
		.loaded        (loaded),
		.word_out      (word_out),
		.word_strobe   (word_strobe),
		.bit_out       (bit_out),
		.error_count   (error_count),
		.words_checked (words_checked),
		.rise_count    (rise_count)
	);

	// one cycle strobe, called on a falling edge
	task automatic pulse_start(input pattern_mode_t m);
		mode  = m;
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
	endtask

	task automatic wait_for_playback(input int words, input string name, inout logic timed_out);
		int waited;
		waited = 0;
		while (!loaded && waited < load_timeout) begin
			@(negedge clock);
			waited++;
		end
		if (!loaded) begin
			$display("timeout: loaded never rose in test %s", name);
			timed_out = 1'b1;
		end else begin
			waited = 0;
			while (words_checked < words && waited < words * word_timeout) begin
				@(negedge clock);
				waited++;
			end
			if (words_checked < words) begin
				$display("timeout: %0d of %0d words played in test %s", words_checked, words, name);
				timed_out = 1'b1;
			end
		end
	endtask

	initial begin
		int            errors_before;
		int            rises_before;
		int            rises_expected;
		int            tests_run;
		int            failed_tests;
		logic          timed_out;
		logic          rise_wrong;
		pattern_mode_t other;
		reset        = 1'b1;
		start        = 1'b0;
		mode         = mode_ramp;
		tests_run    = 0;
		failed_tests = 0;
		timed_out    = 1'b0;
		repeat (10) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		// idle stretch, outputs must stay low
		repeat (20) @(negedge clock);
		for (int t = 0; t < num_tests && !timed_out; t++) begin
			errors_before  = error_count;
			rises_before   = rise_count;
			rises_expected = (test_action[t] == act_reload) ? 2 : 1;
			rise_wrong     = 1'b0;
			tests_run++;
			pulse_start(test_mode[t]);
			if (test_action[t] == act_restart) begin
				// second start in the middle of the write burst
				repeat (5) @(negedge clock);
				other = (test_mode[t] == mode_ramp) ? mode_marker : mode_ramp;
				pulse_start(other);
			end
			wait_for_playback(test_words[t], test_name[t], timed_out);
			if (!timed_out && test_action[t] == act_reload) begin
				// same mode again, prbs reseeded so content repeats
				pulse_start(test_mode[t]);
				wait_for_playback(test_words[t], test_name[t], timed_out);
			end
			if (!timed_out && rise_count - rises_before != rises_expected) begin
				$display("test %s: loaded rose %0d times, expected %0d", test_name[t],
					rise_count - rises_before, rises_expected);
				rise_wrong = 1'b1;
			end
			if (timed_out || rise_wrong || error_count != errors_before) begin
				failed_tests++;
				$display("test %s: FAIL, %0d checker errors", test_name[t],
					error_count - errors_before);
			end else begin
				$display("test %s: pass", test_name[t]);
			end
		end
		$display("tests run %0d, failed %0d, checker errors %0d", tests_run, failed_tests,
			error_count);
		if (failed_tests == 0 && !timed_out && error_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: pattern_synthesizer.sv
`timescale 1ns/1ns

module pattern_synthesizer #(
	parameter int address_depth = 14
) (
	input  logic [address_depth-1:0]        load_address,
	input  fgen_pkg::pattern_mode_t         mode,
	output logic [fgen_pkg::word_width-1:0] pattern_word
);
	import fgen_pkg::*;

	// mask for the address bits below the top byte
	// empty when the ram is only 256 words deep
	localparam logic [address_depth-1:0] low_mask =
		address_depth'((64'd1 << (address_depth - 8)) - 64'd1);

	logic [word_width-1:0]    top_byte;
	logic [word_width-1:0]    low_bits;
	logic [2:0]               top_three;
	logic [word_width-1:0]    comb_word;

	// top 8 address bits, tells where in the ram a marker sits
	assign top_byte  = load_address[address_depth-1 -: word_width];
	// low d-8 bits, zero extended
	assign low_bits  = word_width'(load_address & low_mask);
	// pulse width selector
	assign top_three = load_address[address_depth-1 -: 3];

	// k+1 ones packed from the msb
	assign comb_word = ~({word_width{1'b1}} >> (4'(top_three) + 4'd1));

	always_comb begin
		pattern_word = '0;
		case (mode)
			mode_ramp: begin
				pattern_word = load_address[word_width-1:0];
			end
			mode_marker: begin
				// frame of four words every 32 addresses
				case (load_address[4:0])
					5'd0:    pattern_word = 8'hff;
					5'd1:    pattern_word = top_byte;
					5'd2:    pattern_word = low_bits;
					5'd3:    pattern_word = 8'hff;
					default: pattern_word = '0;
				endcase
			end
			mode_boundary: begin
				// shows any seam between ram blocks
				if (load_address[5:0] == 6'd0) begin
					pattern_word = top_byte;
				end
			end
			mode_pulse_width: begin
				// one pulse per 128 words, width grows through the ram
				if (load_address[6:0] == 7'd0) begin
					pattern_word = comb_word;
				end
			end
			// random words come from the prbs generator
			default: pattern_word = '0;
		endcase
	end

endmodule

// File: prbs_generator.sv
`timescale 1ns/1ns

module prbs_generator (
	input  logic                            clock,
	input  logic                            reset,
	input  logic                            reseed,
	input  logic                            advance,
	output logic [fgen_pkg::word_width-1:0] prbs_word
);
	import fgen_pkg::*;

	// feedback taps for x^31 + x^28 + 1
	localparam int tap_high = 30;
	localparam int tap_low  = 27;

	logic [prbs_width-1:0] lfsr;

	// shift left, new bit 0 from the two taps
	// reseed wins over advance so a load always starts from the same state
	always_ff @(posedge clock) begin
		if (reset || reseed) begin
			lfsr <= prbs_seed;
		end else if (advance) begin
			lfsr <= {lfsr[prbs_width-2:0], lfsr[tap_high] ^ lfsr[tap_low]};
		end
	end

	// low byte of the current state
	assign prbs_word = lfsr[word_width-1:0];

endmodule

// File: ram_loader.sv
`timescale 1ns/1ns

module ram_loader #(
	parameter int address_depth = 14
) (
	input  logic                            clock,
	input  logic                            reset,
	input  logic                            start,
	input  fgen_pkg::pattern_mode_t         mode,
	input  logic [fgen_pkg::word_width-1:0] pattern_word,
	input  logic [fgen_pkg::word_width-1:0] prbs_word,
	output fgen_pkg::pattern_mode_t         latched_mode,
	output logic [address_depth-1:0]        load_address,
	output logic                            write_enable,
	output logic [address_depth-1:0]        write_address,
	output logic [fgen_pkg::word_width-1:0] write_data,
	output logic                            loaded
);
	import fgen_pkg::*;

	localparam logic [address_depth-1:0] last_address = '1;

	loader_state_t         state;
	logic [word_width-1:0] pattern_data;

	// load_address runs one cycle ahead of write_address
	// the pattern word for it is captured on the same edge
	always_ff @(posedge clock) begin
		if (reset) begin
			state         <= load_idle;
			latched_mode  <= mode_ramp;
			load_address  <= '0;
			write_enable  <= 1'b0;
			write_address <= '0;
			loaded        <= 1'b0;
		end else begin
			case (state)
				load_idle, load_done: begin
					if (start) begin
						// mode only sampled here, changes while writing are ignored
						state        <= load_writing;
						latched_mode <= mode;
						load_address <= '0;
						loaded       <= 1'b0;
					end
				end
				load_writing: begin
					if (write_enable && write_address == last_address) begin
						// last word goes into the ram on this edge
						state        <= load_done;
						write_enable <= 1'b0;
						loaded       <= 1'b1;
					end else begin
						write_enable  <= 1'b1;
						write_address <= load_address;
						load_address  <= load_address + 1'b1;
					end
				end
				default: begin
					state <= load_idle;
				end
			endcase
		end
	end

	// deterministic word for the address being registered
	always_ff @(posedge clock) begin
		pattern_data <= pattern_word;
	end

	// prbs steps on every edge that writes, so while a word is pending
	// its state has taken exactly write_address steps from the seed
	assign write_data = (latched_mode == mode_random) ? prbs_word : pattern_data;

	// ram writes only happen inside a load
	// loaded must not rise before the write burst is over
	assert property (@(posedge clock) disable iff (reset)
		write_enable |-> state == load_writing && !loaded)
		else $error("write_enable high outside load_writing or with loaded set");

endmodule

// File: waveform_playback.sv
`timescale 1ns/1ns

module waveform_playback #(
	parameter int address_depth = 14
) (
	input  logic                            clock,
	input  logic                            reset,
	input  logic                            write_enable,
	input  logic [address_depth-1:0]        write_address,
	input  logic [fgen_pkg::word_width-1:0] write_data,
	input  logic                            loaded,
	output logic [fgen_pkg::word_width-1:0] word_out,
	output logic                            word_strobe
);
	import fgen_pkg::*;

	localparam int                   slot_bits = $clog2(word_width);
	localparam logic [slot_bits-1:0] last_slot = slot_bits'(word_width - 1);

	// waveform ram, one word per address
	logic [word_width-1:0]    ram [0:(2**address_depth)-1];
	logic [address_depth-1:0] read_address;
	logic [slot_bits-1:0]     slot;
	logic                     strobe_q;

	// write port, owned by the loader
	always_ff @(posedge clock) begin
		if (write_enable) begin
			ram[write_address] <= write_data;
		end
	end

	// one read per word slot, address wraps at the top of the ram
	always_ff @(posedge clock) begin
		if (reset) begin
			slot         <= '0;
			read_address <= '0;
			strobe_q     <= 1'b0;
			word_out     <= '0;
		end else if (!loaded) begin
			// stopped, next playback starts from address 0
			slot         <= '0;
			read_address <= '0;
			strobe_q     <= 1'b0;
		end else begin
			strobe_q <= (slot == '0);
			if (slot == '0) begin
				word_out     <= ram[read_address];
				read_address <= read_address + 1'b1;
			end
			if (slot == last_slot) begin
				slot <= '0;
			end else begin
				slot <= slot + 1'b1;
			end
		end
	end

	// a reload drops loaded on the same edge a strobe could be issued
	// that last word is dropped
	assign word_strobe = strobe_q & loaded;

	// words are only played from a ram the loader has finished writing
	assert property (@(posedge clock) disable iff (reset)
		word_strobe |-> !write_enable)
		else $error("word_strobe during a ram write");

endmodule

// File: word_serializer.sv
`timescale 1ns/1ns

module word_serializer (
	input  logic                            clock,
	input  logic                            reset,
	input  logic [fgen_pkg::word_width-1:0] word_out,
	input  logic                            word_strobe,
	output logic                            bit_out
);
	import fgen_pkg::*;

	logic [word_width-1:0] shift_reg;

	// load on strobe, then shift toward the msb
	// zeros fill in behind, so the line idles low between words
	always_ff @(posedge clock) begin
		if (reset) begin
			shift_reg <= '0;
		end else if (word_strobe) begin
			shift_reg <= word_out;
		end else begin
			shift_reg <= {shift_reg[word_width-2:0], 1'b0};
		end
	end

	// msb first, bit 7 in the cycle after the strobe
	assign bit_out = shift_reg[word_width-1];

	// a new word must not cut the previous frame short
	assert property (@(posedge clock) disable iff (reset)
		word_strobe |=> !word_strobe [*word_width-1])
		else $error("word_strobe closer than %0d cycles", word_width);

endmodule
